//--- datapath_golden.hex
// program words at @00, four per line, one word each starting at byte address 0x00
// expected stores at @28, one record per line as address then data
// data memory image at @48, words for byte addresses 0x00 to 0x1c
@00
123450B7 00500113 FFD00193 00208233 // lui x1 / addi x2 / addi x3 / add x4
04402023 403102B3 04502223 0021A333 // sw x4 / sub x5 / sw x5 / slt x6
006113B3 4061D433 0061D4B3 0083C533 // sll x7 / sra x8 / srl x9 / xor x10
04A02423 04902623 0030F8B3 0078E933 // sw x10 / sw x9 / and x17 / or x18
0001A993 01390A33 05402823 00002583 // slti x19 / add x20 / sw x20 / lw x11
00B58633 04C02A23 00F67693 00069463 // add x12 load-use / sw x12 / andi x13 / bne taken
04D02C23 1006E713 00D70463 04E02C23 // sw skipped / ori x14 / beq not taken / sw x14
00210463 04202E23 0FF74793 04F02E23 // beq taken / sw skipped / xori x15 / sw x15
00402803 00281463 06002023 11002023 // lw x16 / bne taken on load / sw skipped / sw done
00000000 00000000 00000000 00000000 // no-op padding
@28
00000040 12345005 // add
00000044 00000008 // sub, store data from mem forward
00000048 FFFFFFF4 // xor of sll and sra
0000004C 7FFFFFFE // srl
00000050 1234500B // and / or / slti / add chain
00000054 00000022 // load-use sum
00000058 00000102 // ori after taken bne
0000005C 000001FD // xori after taken beq
00000100 00000022 // done store, load data after taken bne
@48
00000011 00000022 00000033 00000044
00000055 00000066 00000077 00000088

//--- flist.f
+incdir+.
rv32i_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
datapath.sv
tb_clock_gen.sv
datapath_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module datapath_tb \
    -f flist.f -o datapath_sim
./obj_dir/datapath_sim | tee sim.log
if grep -q "Regression passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- datapath_tb.sv
`timescale 1ns/1ns
`include "rv32i_defs.svh"

module datapath_tb;

    // golden image layout in words
    localparam int PROG_WORDS    = 40;
    localparam int EXP_BASE      = 40;
    localparam int EXP_MAX       = 16;
    localparam int DATA_BASE     = 72;
    localparam int DATA_WORDS    = 8;
    localparam int GOLDEN_WORDS  = 128;
    // program ends with a store here
    localparam logic [31:0] DONE_ADDR = 32'h0000_0100;
    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT   = 400;
    localparam int DRAIN_CYCLES  = 8;

    logic             clk;
    logic             reset_i;
    rv32i_pkg::word_t instr_addr;
    rv32i_pkg::word_t instr_rdata;
    logic             data_read;
    logic             data_write;
    rv32i_pkg::word_t data_addr;
    rv32i_pkg::word_t data_wdata;
    rv32i_pkg::word_t data_rdata;

    rv32i_pkg::word_t golden [GOLDEN_WORDS];
    rv32i_pkg::word_t dmem [DATA_WORDS];
    // expected store records in program order
    rv32i_pkg::word_t exp_addr [$];
    rv32i_pkg::word_t exp_data [$];

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    bit timed_out;

    tb_clock_gen clkgen0 (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    datapath dut0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_addr_o  (instr_addr),
        .instr_rdata_i (instr_rdata),
        .data_read_o   (data_read),
        .data_write_o  (data_write),
        .data_addr_o   (data_addr),
        .data_wdata_o  (data_wdata),
        .data_rdata_i  (data_rdata)
    );

    // combinational instruction rom
    // past the program it reads zero and decodes as a no-op
    always_comb begin
        if ($isunknown(instr_addr) || (instr_addr >= 32'(PROG_WORDS * 4))) begin
            instr_rdata = '0;
        end else begin
            instr_rdata = golden[instr_addr[8:2]];
        end
    end

    // data image at 0x00-0x1f
    // anything else returns a pattern of the full address
    // read data is zero unless the read strobe is high
    always_comb begin
        if ((data_read !== 1'b1) || $isunknown(data_addr)) begin
            data_rdata = '0;
        end else if (data_addr < 32'(DATA_WORDS * 4)) begin
            data_rdata = dmem[data_addr[4:2]];
        end else begin
            data_rdata = data_addr ^ 32'h5a5a_5a5a;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %0s: FAILED", name);
        end else begin
            $display("test %0s: ok", name);
        end
    endtask

    // stores into the image region update it
    task automatic store_word(input rv32i_pkg::word_t addr, input rv32i_pkg::word_t wdata);
        if (addr < 32'(DATA_WORDS * 4)) begin
            dmem[addr[4:2]] = wdata;
        end
    endtask

    task automatic load_golden();
        int i;
        $readmemh("datapath_golden.hex", golden);
        for (i = 0; i < DATA_WORDS; i++) begin
            dmem[i] = golden[DATA_BASE + i];
        end
        // records run up to and including the done store
        i = 0;
        while (i < EXP_MAX) begin
            exp_addr.push_back(golden[EXP_BASE + 2 * i]);
            exp_data.push_back(golden[EXP_BASE + 2 * i + 1]);
            if (golden[EXP_BASE + 2 * i] == DONE_ADDR) begin
                break;
            end
            i++;
        end
    endtask

    initial begin : main_seq
        int err_mark;
        int cyc;
        int rec;
        bit done;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        load_golden();

        // strobes quiet while reset is held
        // outputs sampled on the falling edge
        err_mark = errors;
        cyc = 0;
        @(negedge clk);
        while (reset_i && (cyc < RESET_TIMEOUT)) begin
            check_value("data_read_o", 32'(data_read), 32'h0);
            check_value("data_write_o", 32'(data_write), 32'h0);
            cyc++;
            @(negedge clk);
        end
        if (reset_i) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
            errors++;
        end else begin
            // first cycle out of reset
            check_value("data_read_o", 32'(data_read), 32'h0);
            check_value("data_write_o", 32'(data_write), 32'h0);
            check_value("instr_addr_o", instr_addr, `RESET_PC);
        end
        finish_test("reset_state", err_mark);

        // every store against the next record in order
        // skipped stores show up as mismatches here
        err_mark = errors;
        rec = 0;
        done = 1'b0;
        cyc = 0;
        while (!done && !timed_out) begin
            if (data_write) begin
                if (rec < exp_addr.size()) begin
                    check_value("data_addr_o", data_addr, exp_addr[rec]);
                    check_value("data_wdata_o", data_wdata, exp_data[rec]);
                end else begin
                    $display("store to 0x%08h with no expected record left", data_addr);
                    errors++;
                end
                store_word(data_addr, data_wdata);
                done = (data_addr == DONE_ADDR);
                rec++;
            end
            if (!done) begin
                if (cyc == RUN_TIMEOUT) begin
                    $display("timeout: no store to the done address after %0d cycles", cyc);
                    timed_out = 1'b1;
                    errors++;
                end else begin
                    cyc++;
                    @(negedge clk);
                end
            end
        end
        finish_test("store_stream", err_mark);

        // all records consumed and nothing written after the done store
        err_mark = errors;
        if (!timed_out) begin
            check_value("store_count", 32'(rec), 32'(exp_addr.size()));
        end
        cyc = 0;
        while (!timed_out && (cyc < DRAIN_CYCLES)) begin
            @(negedge clk);
            if (data_write) begin
                $display("store to 0x%08h after the done store", data_addr);
                errors++;
            end
            cyc++;
        end
        finish_test("store_end", err_mark);

        $display("tests %0d run, %0d failed, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if ((errors == 0) && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held over four rising edges
    // released 1 ns after the fourth edge like any other input
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

//--- datapath.sv
`timescale 1ns/1ns

module datapath (
    input  logic               clk,
    input  logic               reset_i,
    output rv32i_pkg::word_t   instr_addr_o,
    input  rv32i_pkg::word_t   instr_rdata_i,
    output logic               data_read_o,
    output logic               data_write_o,
    output rv32i_pkg::word_t   data_addr_o,
    output rv32i_pkg::word_t   data_wdata_o,
    input  rv32i_pkg::word_t   data_rdata_i
);

    // hazard unit outputs
    logic                 stall;
    rv32i_pkg::fwd_sel_t  fwd_a;
    rv32i_pkg::fwd_sel_t  fwd_b;
    logic                 fwd_br_a;
    logic                 fwd_br_b;

    // decode outputs
    logic                 branch_taken;
    rv32i_pkg::word_t     branch_target;
    rv32i_pkg::reg_addr_t id_rs1;
    rv32i_pkg::reg_addr_t id_rs2;
    rv32i_pkg::reg_addr_t id_rd;
    rv32i_pkg::word_t     id_rs1_data;
    rv32i_pkg::word_t     id_rs2_data;
    rv32i_pkg::word_t     id_imm;
    rv32i_pkg::alu_op_t   id_alu_op;
    logic                 id_use_imm;
    logic                 id_reg_we;
    logic                 id_mem_read;
    logic                 id_mem_write;
    logic                 id_is_branch;

    // execute outputs
    rv32i_pkg::reg_addr_t ex_rs1;
    rv32i_pkg::reg_addr_t ex_rs2;
    rv32i_pkg::reg_addr_t ex_rd;
    logic                 ex_reg_we;
    logic                 ex_mem_read;
    logic                 ex_mem_write;
    rv32i_pkg::word_t     alu_result;
    rv32i_pkg::word_t     store_data;

    // memory and writeback outputs
    rv32i_pkg::reg_addr_t mem_rd;
    logic                 mem_reg_we;
    logic                 mem_is_load;
    rv32i_pkg::word_t     mem_alu_result;
    logic                 wb_we;
    rv32i_pkg::reg_addr_t wb_rd;
    rv32i_pkg::word_t     wb_data;

    fetch_stage fetch0 (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .pc_o            (instr_addr_o)
    );

    // a taken branch squashes the fall-through fetch
    decode_stage decode0 (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall),
        .flush_i          (branch_taken),
        .pc_i             (instr_addr_o),
        .instr_i          (instr_rdata_i),
        .wb_we_i          (wb_we),
        .wb_rd_i          (wb_rd),
        .wb_data_i        (wb_data),
        .fwd_br_a_i       (fwd_br_a),
        .fwd_br_b_i       (fwd_br_b),
        .mem_alu_result_i (mem_alu_result),
        .rs1_o            (id_rs1),
        .rs2_o            (id_rs2),
        .rd_o             (id_rd),
        .rs1_data_o       (id_rs1_data),
        .rs2_data_o       (id_rs2_data),
        .imm_o            (id_imm),
        .alu_op_o         (id_alu_op),
        .use_imm_o        (id_use_imm),
        .reg_we_o         (id_reg_we),
        .mem_read_o       (id_mem_read),
        .mem_write_o      (id_mem_write),
        .is_branch_o      (id_is_branch),
        .branch_taken_o   (branch_taken),
        .branch_target_o  (branch_target)
    );

    execute_stage execute0 (
        .clk              (clk),
        .reset_i          (reset_i),
        .bubble_i         (stall),
        .rs1_i            (id_rs1),
        .rs2_i            (id_rs2),
        .rd_i             (id_rd),
        .rs1_data_i       (id_rs1_data),
        .rs2_data_i       (id_rs2_data),
        .imm_i            (id_imm),
        .alu_op_i         (id_alu_op),
        .use_imm_i        (id_use_imm),
        .reg_we_i         (id_reg_we),
        .mem_read_i       (id_mem_read),
        .mem_write_i      (id_mem_write),
        .fwd_a_i          (fwd_a),
        .fwd_b_i          (fwd_b),
        .mem_alu_result_i (mem_alu_result),
        .wb_data_i        (wb_data),
        .ex_rs1_o         (ex_rs1),
        .ex_rs2_o         (ex_rs2),
        .ex_rd_o          (ex_rd),
        .ex_reg_we_o      (ex_reg_we),
        .ex_mem_read_o    (ex_mem_read),
        .ex_mem_write_o   (ex_mem_write),
        .alu_result_o     (alu_result),
        .store_data_o     (store_data)
    );

    memory_stage memory0 (
        .clk              (clk),
        .reset_i          (reset_i),
        .ex_rd_i          (ex_rd),
        .ex_reg_we_i      (ex_reg_we),
        .ex_mem_read_i    (ex_mem_read),
        .ex_mem_write_i   (ex_mem_write),
        .alu_result_i     (alu_result),
        .store_data_i     (store_data),
        .data_rdata_i     (data_rdata_i),
        .data_read_o      (data_read_o),
        .data_write_o     (data_write_o),
        .data_addr_o      (data_addr_o),
        .data_wdata_o     (data_wdata_o),
        .mem_rd_o         (mem_rd),
        .mem_reg_we_o     (mem_reg_we),
        .mem_is_load_o    (mem_is_load),
        .mem_alu_result_o (mem_alu_result),
        .wb_we_o          (wb_we),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data)
    );

    hazard_unit hazard0 (
        .id_rs1_i       (id_rs1),
        .id_rs2_i       (id_rs2),
        .id_is_branch_i (id_is_branch),
        .ex_rs1_i       (ex_rs1),
        .ex_rs2_i       (ex_rs2),
        .ex_rd_i        (ex_rd),
        .ex_reg_we_i    (ex_reg_we),
        .ex_mem_read_i  (ex_mem_read),
        .mem_rd_i       (mem_rd),
        .mem_reg_we_i   (mem_reg_we),
        .mem_is_load_i  (mem_is_load),
        .wb_rd_i        (wb_rd),
        .wb_we_i        (wb_we),
        .stall_o        (stall),
        .fwd_a_o        (fwd_a),
        .fwd_b_o        (fwd_b),
        .fwd_br_a_o     (fwd_br_a),
        .fwd_br_b_o     (fwd_br_b)
    );

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ns
`include "rv32i_defs.svh"

module hazard_unit (
    input  rv32i_pkg::reg_addr_t   id_rs1_i,
    input  rv32i_pkg::reg_addr_t   id_rs2_i,
    input  logic                   id_is_branch_i,
    input  rv32i_pkg::reg_addr_t   ex_rs1_i,
    input  rv32i_pkg::reg_addr_t   ex_rs2_i,
    input  rv32i_pkg::reg_addr_t   ex_rd_i,
    input  logic                   ex_reg_we_i,
    input  logic                   ex_mem_read_i,
    input  rv32i_pkg::reg_addr_t   mem_rd_i,
    input  logic                   mem_reg_we_i,
    input  logic                   mem_is_load_i,
    input  rv32i_pkg::reg_addr_t   wb_rd_i,
    input  logic                   wb_we_i,
    output logic                   stall_o,
    output rv32i_pkg::fwd_sel_t    fwd_a_o,
    output rv32i_pkg::fwd_sel_t    fwd_b_o,
    output logic                   fwd_br_a_o,
    output logic                   fwd_br_b_o
);

    logic ex_hits_id;
    logic mem_hits_id;
    logic load_use;
    logic branch_wait;

    // mem before wb, x0 never forwarded
    function automatic rv32i_pkg::fwd_sel_t pick_src(input rv32i_pkg::reg_addr_t rs);
        if (mem_reg_we_i && (mem_rd_i != '0) && (mem_rd_i == rs)) begin
            return `FWD_MEM;
        end else if (wb_we_i && (wb_rd_i != '0) && (wb_rd_i == rs)) begin
            return `FWD_WB;
        end
        return `FWD_REG;
    endfunction

    assign fwd_a_o = pick_src(ex_rs1_i);
    assign fwd_b_o = pick_src(ex_rs2_i);

    // decode sources written by the instruction in execute / memory
    assign ex_hits_id  = (ex_rd_i != '0) && ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));
    assign mem_hits_id = (mem_rd_i != '0) && ((mem_rd_i == id_rs1_i) || (mem_rd_i == id_rs2_i));

    assign load_use = ex_mem_read_i && ex_hits_id;

    // branch compares in decode, so any ex producer and a mem load must wait
    assign branch_wait = id_is_branch_i
                      && ((ex_reg_we_i && ex_hits_id) || (mem_is_load_i && mem_hits_id));

    assign stall_o = load_use || branch_wait;

    // alu result in ex/mem goes straight to the comparator
    assign fwd_br_a_o = mem_reg_we_i && !mem_is_load_i && (mem_rd_i != '0)
                     && (mem_rd_i == id_rs1_i);
    assign fwd_br_b_o = mem_reg_we_i && !mem_is_load_i && (mem_rd_i != '0)
                     && (mem_rd_i == id_rs2_i);

endmodule

//--- memory_stage.sv
`timescale 1ns/1ns

module memory_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  rv32i_pkg::reg_addr_t   ex_rd_i,
    input  logic                   ex_reg_we_i,
    input  logic                   ex_mem_read_i,
    input  logic                   ex_mem_write_i,
    input  rv32i_pkg::word_t       alu_result_i,
    input  rv32i_pkg::word_t       store_data_i,
    input  rv32i_pkg::word_t       data_rdata_i,
    output logic                   data_read_o,
    output logic                   data_write_o,
    output rv32i_pkg::word_t       data_addr_o,
    output rv32i_pkg::word_t       data_wdata_o,
    output rv32i_pkg::reg_addr_t   mem_rd_o,
    output logic                   mem_reg_we_o,
    output logic                   mem_is_load_o,
    output rv32i_pkg::word_t       mem_alu_result_o,
    output logic                   wb_we_o,
    output rv32i_pkg::reg_addr_t   wb_rd_o,
    output rv32i_pkg::word_t       wb_data_o
);

    // ex/mem control, strobes low out of reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_reg_we_o  <= 1'b0;
            mem_is_load_o <= 1'b0;
            data_write_o  <= 1'b0;
        end else begin
            mem_reg_we_o  <= ex_reg_we_i;
            mem_is_load_o <= ex_mem_read_i;
            data_write_o  <= ex_mem_write_i;
        end
    end

    // ex/mem payload
    always_ff @(posedge clk) begin
        mem_rd_o         <= ex_rd_i;
        mem_alu_result_o <= alu_result_i;
        data_wdata_o     <= store_data_i;
    end

    // data port, single cycle
    assign data_read_o = mem_is_load_o;
    assign data_addr_o = mem_alu_result_o;

    // mem/wb, result already muxed so wb is register outputs only
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= mem_reg_we_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= mem_rd_o;
        wb_data_o <= mem_is_load_o ? data_rdata_i : mem_alu_result_o;
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns
`include "rv32i_defs.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   bubble_i,
    input  rv32i_pkg::reg_addr_t   rs1_i,
    input  rv32i_pkg::reg_addr_t   rs2_i,
    input  rv32i_pkg::reg_addr_t   rd_i,
    input  rv32i_pkg::word_t       rs1_data_i,
    input  rv32i_pkg::word_t       rs2_data_i,
    input  rv32i_pkg::word_t       imm_i,
    input  rv32i_pkg::alu_op_t     alu_op_i,
    input  logic                   use_imm_i,
    input  logic                   reg_we_i,
    input  logic                   mem_read_i,
    input  logic                   mem_write_i,
    input  rv32i_pkg::fwd_sel_t    fwd_a_i,
    input  rv32i_pkg::fwd_sel_t    fwd_b_i,
    input  rv32i_pkg::word_t       mem_alu_result_i,
    input  rv32i_pkg::word_t       wb_data_i,
    output rv32i_pkg::reg_addr_t   ex_rs1_o,
    output rv32i_pkg::reg_addr_t   ex_rs2_o,
    output rv32i_pkg::reg_addr_t   ex_rd_o,
    output logic                   ex_reg_we_o,
    output logic                   ex_mem_read_o,
    output logic                   ex_mem_write_o,
    output rv32i_pkg::word_t       alu_result_o,
    output rv32i_pkg::word_t       store_data_o
);

    rv32i_pkg::word_t   ex_rs1_data;
    rv32i_pkg::word_t   ex_rs2_data;
    rv32i_pkg::word_t   ex_imm;
    rv32i_pkg::alu_op_t ex_alu_op;
    logic               ex_use_imm;
    rv32i_pkg::word_t   op_a;
    rv32i_pkg::word_t   fwd_b;
    rv32i_pkg::word_t   op_b;

    // id/ex control, a stalled decode sends a bubble
    always_ff @(posedge clk) begin
        if (reset_i || bubble_i) begin
            ex_rd_o        <= '0;
            ex_reg_we_o    <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end else begin
            ex_rd_o        <= rd_i;
            ex_reg_we_o    <= reg_we_i;
            ex_mem_read_o  <= mem_read_i;
            ex_mem_write_o <= mem_write_i;
        end
    end

    // id/ex payload
    always_ff @(posedge clk) begin
        ex_rs1_o    <= rs1_i;
        ex_rs2_o    <= rs2_i;
        ex_rs1_data <= rs1_data_i;
        ex_rs2_data <= rs2_data_i;
        ex_imm      <= imm_i;
        ex_alu_op   <= alu_op_i;
        ex_use_imm  <= use_imm_i;
    end

    // operand forwarding
    always_comb begin
        case (fwd_a_i)
            `FWD_MEM: op_a = mem_alu_result_i;
            `FWD_WB:  op_a = wb_data_i;
            default:  op_a = ex_rs1_data;
        endcase
        case (fwd_b_i)
            `FWD_MEM: fwd_b = mem_alu_result_i;
            `FWD_WB:  fwd_b = wb_data_i;
            default:  fwd_b = ex_rs2_data;
        endcase
    end

    assign op_b         = ex_use_imm ? ex_imm : fwd_b;
    assign store_data_o = fwd_b;

    always_comb begin
        case (ex_alu_op)
            `ALU_SUB: alu_result_o = op_a - op_b;
            `ALU_AND: alu_result_o = op_a & op_b;
            `ALU_OR:  alu_result_o = op_a | op_b;
            `ALU_XOR: alu_result_o = op_a ^ op_b;
            `ALU_SLT: alu_result_o = {31'd0, $signed(op_a) < $signed(op_b)};
            `ALU_SLL: alu_result_o = op_a << op_b[4:0];
            `ALU_SRL: alu_result_o = op_a >> op_b[4:0];
            `ALU_SRA: alu_result_o = $signed(op_a) >>> op_b[4:0];
            // add, also address calc and lui
            default:  alu_result_o = op_a + op_b;
        endcase
    end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns
`include "rv32i_defs.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  rv32i_pkg::word_t       pc_i,
    input  rv32i_pkg::word_t       instr_i,
    input  logic                   wb_we_i,
    input  rv32i_pkg::reg_addr_t   wb_rd_i,
    input  rv32i_pkg::word_t       wb_data_i,
    input  logic                   fwd_br_a_i,
    input  logic                   fwd_br_b_i,
    input  rv32i_pkg::word_t       mem_alu_result_i,
    output rv32i_pkg::reg_addr_t   rs1_o,
    output rv32i_pkg::reg_addr_t   rs2_o,
    output rv32i_pkg::reg_addr_t   rd_o,
    output rv32i_pkg::word_t       rs1_data_o,
    output rv32i_pkg::word_t       rs2_data_o,
    output rv32i_pkg::word_t       imm_o,
    output rv32i_pkg::alu_op_t     alu_op_o,
    output logic                   use_imm_o,
    output logic                   reg_we_o,
    output logic                   mem_read_o,
    output logic                   mem_write_o,
    output logic                   is_branch_o,
    output logic                   branch_taken_o,
    output rv32i_pkg::word_t       branch_target_o
);

    rv32i_pkg::word_t if_pc;
    rv32i_pkg::word_t if_instr;
    rv32i_pkg::word_t regs [`NUM_REGS];
    rv32i_pkg::word_t i_imm;
    rv32i_pkg::word_t s_imm;
    rv32i_pkg::word_t b_imm;
    rv32i_pkg::word_t u_imm;
    rv32i_pkg::word_t br_a;
    rv32i_pkg::word_t br_b;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             reads_rs2;
    logic             br_cond;

    // if/id, cleared instr is opcode 0 which decodes as a no-op
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            if_instr <= '0;
        end else if (!stall_i) begin
            if_instr <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            if_pc <= pc_i;
        end
    end

    // register file write at end of wb
    always_ff @(posedge clk) begin
        if (wb_we_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // x0 is zero; same-cycle write is passed straight through
    function automatic rv32i_pkg::word_t read_reg(input rv32i_pkg::reg_addr_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_we_i && (wb_rd_i == idx)) begin
            return wb_data_i;
        end
        return regs[idx];
    endfunction

    assign opcode = if_instr[6:0];
    assign funct3 = if_instr[14:12];
    assign funct7 = if_instr[31:25];

    // immediate formats
    assign i_imm = {{20{if_instr[31]}}, if_instr[31:20]};
    assign s_imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign b_imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign u_imm = {if_instr[31:12], 12'h000};

    // control decode
    always_comb begin
        alu_op_o    = `ALU_ADD;
        use_imm_o   = 1'b0;
        reg_we_o    = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        reads_rs2   = 1'b0;
        imm_o       = i_imm;
        case (opcode)
            `OP_REG: begin
                reg_we_o  = 1'b1;
                reads_rs2 = 1'b1;
                case (funct3)
                    `F3_ADD: alu_op_o = (funct7 == `F7_ALT) ? `ALU_SUB : `ALU_ADD;
                    `F3_SLL: alu_op_o = `ALU_SLL;
                    `F3_SLT: alu_op_o = `ALU_SLT;
                    `F3_XOR: alu_op_o = `ALU_XOR;
                    `F3_SR:  alu_op_o = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
                    `F3_OR:  alu_op_o = `ALU_OR;
                    `F3_AND: alu_op_o = `ALU_AND;
                    // sltu not supported
                    default: reg_we_o = 1'b0;
                endcase
            end
            `OP_IMM: begin
                reg_we_o  = 1'b1;
                use_imm_o = 1'b1;
                case (funct3)
                    `F3_ADD: alu_op_o = `ALU_ADD;
                    `F3_SLT: alu_op_o = `ALU_SLT;
                    `F3_XOR: alu_op_o = `ALU_XOR;
                    `F3_OR:  alu_op_o = `ALU_OR;
                    `F3_AND: alu_op_o = `ALU_AND;
                    // immediate shifts and sltiu run as no-ops
                    default: reg_we_o = 1'b0;
                endcase
            end
            `OP_LUI: begin
                reg_we_o  = 1'b1;
                use_imm_o = 1'b1;
                imm_o     = u_imm;
            end
            `OP_LOAD: begin
                reg_we_o   = 1'b1;
                mem_read_o = 1'b1;
                use_imm_o  = 1'b1;
            end
            `OP_STORE: begin
                mem_write_o = 1'b1;
                use_imm_o   = 1'b1;
                reads_rs2   = 1'b1;
                imm_o       = s_imm;
            end
            `OP_BRANCH: reads_rs2 = 1'b1;
            default: ;
        endcase
    end

    // lui reads x0 so execute adds imm to zero
    assign rs1_o = (opcode == `OP_LUI) ? '0 : if_instr[19:15];
    // rs2 field is immediate bits in other formats
    assign rs2_o = reads_rs2 ? if_instr[24:20] : '0;
    assign rd_o  = if_instr[11:7];

    assign rs1_data_o = read_reg(rs1_o);
    assign rs2_data_o = read_reg(rs2_o);

    // branch compare, alu result from ex/mem forwarded in
    assign br_a = fwd_br_a_i ? mem_alu_result_i : rs1_data_o;
    assign br_b = fwd_br_b_i ? mem_alu_result_i : rs2_data_o;

    always_comb begin
        case (funct3)
            `F3_BEQ: br_cond = (br_a == br_b);
            `F3_BNE: br_cond = (br_a != br_b);
            default: br_cond = 1'b0;
        endcase
    end

    assign is_branch_o     = (opcode == `OP_BRANCH);
    assign branch_taken_o  = is_branch_o && br_cond && !stall_i;
    assign branch_target_o = if_pc + b_imm;

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ns
`include "rv32i_defs.svh"

module fetch_stage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  logic               branch_taken_i,
    input  rv32i_pkg::word_t   branch_target_i,
    output rv32i_pkg::word_t   pc_o
);

    rv32i_pkg::word_t pc;
    rv32i_pkg::word_t pc_next;

    // stall wins, decode never branches while stalled anyway
    always_comb begin
        if (stall_i) begin
            pc_next = pc;
        end else if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // pc drives the instruction port directly
    assign pc_o = pc;

endmodule

//--- rv32i_pkg.sv
`include "rv32i_defs.svh"

package rv32i_pkg;

    // data or address word
    typedef logic [`XLEN-1:0] word_t;

    // register file index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // alu operation, see ALU_* codes
    typedef logic [3:0] alu_op_t;

    // execute operand select, see FWD_* codes
    typedef logic [1:0] fwd_sel_t;

endpackage

//--- rv32i_defs.svh
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define RESET_PC    32'h0000_0000

// major opcodes, rv32i base encoding
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011

// funct3 for alu ops
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 for branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

// funct7 picks sub / sra
`define F7_ALT      7'b0100000

// internal alu op codes
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLT     4'd5
`define ALU_SLL     4'd6
`define ALU_SRL     4'd7
`define ALU_SRA     4'd8

// execute operand sources
`define FWD_REG     2'd0
`define FWD_MEM     2'd1
`define FWD_WB      2'd2

`endif
